//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath width
    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [5:0]      shamt_t;
    typedef logic [4:0]      alu_op_t;

    // operation codes, anything else returns zero
    localparam alu_op_t op_add    = 5'd0;
    localparam alu_op_t op_sub    = 5'd1;
    localparam alu_op_t op_pass_a = 5'd2;
    localparam alu_op_t op_pass_b = 5'd3;
    localparam alu_op_t op_xor    = 5'd4;
    localparam alu_op_t op_or     = 5'd5;
    localparam alu_op_t op_and    = 5'd6;
    localparam alu_op_t op_sll    = 5'd7;
    localparam alu_op_t op_srl    = 5'd8;
    localparam alu_op_t op_sra    = 5'd9;
    localparam alu_op_t op_slt    = 5'd10;
    localparam alu_op_t op_sltu   = 5'd11;
    localparam alu_op_t op_eq     = 5'd12;
    localparam alu_op_t op_ge     = 5'd13;
    localparam alu_op_t op_geu    = 5'd14;
    localparam alu_op_t op_mul    = 5'd15;
    localparam alu_op_t op_div    = 5'd16;
    localparam alu_op_t op_divu   = 5'd17;
    localparam alu_op_t op_rem    = 5'd18;
    localparam alu_op_t op_remu   = 5'd19;

    // operand source selectors
    typedef logic [1:0] sel_a_t;
    typedef logic [1:0] sel_b_t;

    localparam sel_a_t sel_a_pc  = 2'd0;
    localparam sel_a_t sel_a_rs1 = 2'd1;

    localparam sel_b_t sel_b_imm = 2'd0;
    localparam sel_b_t sel_b_rs2 = 2'd1;
    localparam sel_b_t sel_b_csr = 2'd2;

    typedef struct packed {
        alu_op_t op;
        sel_a_t  sel_a;
        sel_b_t  sel_b;
        logic    word;
        xlen_t   pc;
        xlen_t   rs1;
        xlen_t   rs2;
        xlen_t   csr;
        xlen_t   imm;
    } exec_req_t;

    // which result the divider hands back
    typedef logic [1:0] div_kind_t;

    localparam div_kind_t div_s = 2'd0;
    localparam div_kind_t div_u = 2'd1;
    localparam div_kind_t rem_s = 2'd2;
    localparam div_kind_t rem_u = 2'd3;

    typedef struct packed {
        xlen_t     a;
        xlen_t     b;
        div_kind_t kind;
    } muldiv_req_t;

    // one bit per cycle for both sequential units
    localparam int cycles_per_bit_iter = 64;
    localparam int iter_cnt_w = $clog2(cycles_per_bit_iter);

    typedef logic [iter_cnt_w-1:0] iter_cnt_t;

    localparam iter_cnt_t iter_last = iter_cnt_t'(cycles_per_bit_iter - 1);

endpackage

`default_nettype wire

//--- verilog/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  exec_pkg::xlen_t   a,
    input  exec_pkg::xlen_t   b,
    input  exec_pkg::alu_op_t op,
    input  wire               word,
    output exec_pkg::xlen_t   y
);

    import exec_pkg::*;

    shamt_t      shamt;
    logic [31:0] sra_word;
    xlen_t       sra_res;
    logic        lt_s;
    logic        lt_u;

    // only the low six bits of b count as shift amount
    assign shamt = b[5:0];

    // word mode: arithmetic shift of the low half, upper half zero
    assign sra_word = $signed(a[31:0]) >>> shamt;

    always_comb begin
        if (word) begin
            sra_res = {32'b0, sra_word};
        end else begin
            sra_res = $signed(a) >>> shamt;
        end
    end

    // shared by slt/ge and sltu/geu
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            op_add: begin
                y = a + b;
            end
            op_sub: begin
                y = a - b;
            end
            op_pass_a: begin
                y = a;
            end
            op_pass_b: begin
                y = b;
            end
            op_xor: begin
                y = a ^ b;
            end
            op_or: begin
                y = a | b;
            end
            op_and: begin
                y = a & b;
            end
            op_sll: begin
                y = a << shamt;
            end
            op_srl: begin
                y = a >> shamt;
            end
            op_sra: begin
                y = sra_res;
            end
            op_slt: begin
                y = xlen_t'(lt_s);
            end
            op_sltu: begin
                y = xlen_t'(lt_u);
            end
            op_eq: begin
                y = xlen_t'(a == b);
            end
            op_ge: begin
                y = xlen_t'(!lt_s);
            end
            op_geu: begin
                y = xlen_t'(!lt_u);
            end
            // sequential ops and unknown codes
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/seq_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire                   flush,
    input  exec_pkg::muldiv_req_t req,
    output logic                  fin,
    output exec_pkg::xlen_t       p
);

    import exec_pkg::*;

    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } state_t;

    state_t    state;
    iter_cnt_t cnt;
    xlen_t     acc;
    xlen_t     mcand;
    xlen_t     mplier;

    // control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else if (flush) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        // bit 0 is taken on the start edge
                        state <= run;
                        cnt   <= iter_cnt_t'(1);
                    end
                end
                run: begin
                    cnt <= cnt + iter_cnt_t'(1);
                    if (cnt == iter_last) begin
                        state <= finish;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // the low 64 bits of shift-and-add match for signed and unsigned operands
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            acc    <= req.b[0] ? req.a : '0;
            mcand  <= req.a << 1;
            mplier <= req.b >> 1;
        end else if (state == run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign fin = (state == finish);
    assign p   = acc;

endmodule

`default_nettype wire

//--- verilog/seq_divider.sv
`timescale 1ns/1ps
`default_nettype none

module seq_divider (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire                   flush,
    input  exec_pkg::muldiv_req_t req,
    output logic                  fin,
    output exec_pkg::xlen_t       q
);

    import exec_pkg::*;

    typedef enum logic [1:0] {
        idle,
        run,
        fixup
    } state_t;

    // partial remainder and quotient move together
    typedef struct packed {
        xlen_t rem;
        xlen_t quo;
    } div_pair_t;

    // one restoring step
    function automatic div_pair_t div_step(input div_pair_t cur, input xlen_t dvs);
        logic [xlen:0] sh;
        div_pair_t     nxt;
        sh      = {cur.rem, cur.quo[xlen-1]};
        nxt.quo = {cur.quo[xlen-2:0], 1'b0};
        if (sh >= {1'b0, dvs}) begin
            nxt.rem    = xlen_t'(sh - {1'b0, dvs});
            nxt.quo[0] = 1'b1;
        end else begin
            nxt.rem = sh[xlen-1:0];
        end
        return nxt;
    endfunction

    state_t    state;
    iter_cnt_t cnt;
    div_pair_t pair;
    div_pair_t first;
    xlen_t     dvs;
    xlen_t     a_abs;
    xlen_t     b_abs;
    logic      is_signed;
    logic      a_neg;
    logic      b_neg;
    logic      neg_q;
    logic      neg_r;
    logic      want_rem;

    assign is_signed = (req.kind == div_s) || (req.kind == rem_s);
    assign a_neg     = is_signed && req.a[xlen-1];
    assign b_neg     = is_signed && req.b[xlen-1];
    assign a_abs     = a_neg ? -req.a : req.a;
    assign b_abs     = b_neg ? -req.b : req.b;

    // first step runs on the start edge
    assign first = div_step('{rem: '0, quo: a_abs}, b_abs);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
            fin   <= 1'b0;
        end else if (flush) begin
            state <= idle;
            cnt   <= '0;
            fin   <= 1'b0;
        end else begin
            fin <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        cnt   <= iter_cnt_t'(1);
                    end
                end
                run: begin
                    cnt <= cnt + iter_cnt_t'(1);
                    if (cnt == iter_last) begin
                        state <= fixup;
                    end
                end
                fixup: begin
                    fin   <= 1'b1;
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            pair     <= first;
            dvs      <= b_abs;
            // zero divisor keeps the all-ones quotient unsigned
            neg_q    <= (a_neg ^ b_neg) && (req.b != '0);
            neg_r    <= a_neg;
            want_rem <= (req.kind == rem_s) || (req.kind == rem_u);
        end else if (state == run) begin
            pair <= div_step(pair, dvs);
        end else if (state == fixup) begin
            // min / -1 lands on min and zero remainder without a special case
            if (want_rem) begin
                q <= neg_r ? -pair.rem : pair.rem;
            end else begin
                q <= neg_q ? -pair.quo : pair.quo;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  exec_pkg::exec_req_t req,
    input  wire                 issue,
    input  wire                 flush,
    output exec_pkg::xlen_t     res,
    output logic                done,
    output logic                busy
);

    import exec_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_mul,
        wait_div
    } state_t;

    state_t      state;
    xlen_t       op_a;
    xlen_t       op_b;
    xlen_t       alu_y;
    xlen_t       mul_p;
    xlen_t       div_q;
    logic        mul_fin;
    logic        div_fin;
    logic        is_mul;
    logic        is_div;
    logic        accept;
    div_kind_t   div_kind;
    muldiv_req_t md_req;

    // operand a: pc or rs1, word mode zero-extends low half of rs1
    always_comb begin
        if (req.sel_a == sel_a_rs1) begin
            op_a = req.word ? {32'b0, req.rs1[31:0]} : req.rs1;
        end else begin
            op_a = req.pc;
        end
    end

    always_comb begin
        case (req.sel_b)
            sel_b_rs2: op_b = req.rs2;
            sel_b_csr: op_b = req.csr;
            default:   op_b = req.imm;
        endcase
    end

    // op class and divider result kind
    always_comb begin
        is_mul   = (req.op == op_mul);
        is_div   = 1'b1;
        div_kind = rem_u;
        case (req.op)
            op_div:  div_kind = div_s;
            op_divu: div_kind = div_u;
            op_rem:  div_kind = rem_s;
            op_remu: div_kind = rem_u;
            default: is_div = 1'b0;
        endcase
    end

    assign md_req = '{a: op_a, b: op_b, kind: div_kind};

    // flush drops a same-cycle issue
    assign accept = issue && !flush && (state == idle);

    int_alu u_alu (
        .a    (op_a),
        .b    (op_b),
        .op   (req.op),
        .word (req.word),
        .y    (alu_y)
    );

    seq_multiplier u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .start (accept && is_mul),
        .flush (flush),
        .req   (md_req),
        .fin   (mul_fin),
        .p     (mul_p)
    );

    seq_divider u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .start (accept && is_div),
        .flush (flush),
        .req   (md_req),
        .fin   (div_fin),
        .q     (div_q)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            done  <= 1'b0;
            res   <= '0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                state <= idle;
            end else begin
                case (state)
                    idle: begin
                        if (accept && is_mul) begin
                            state <= wait_mul;
                        end else if (accept && is_div) begin
                            state <= wait_div;
                        end else if (accept) begin
                            res  <= alu_y;
                            done <= 1'b1;
                        end
                    end
                    wait_mul: begin
                        if (mul_fin) begin
                            res   <= mul_p;
                            done  <= 1'b1;
                            state <= idle;
                        end
                    end
                    wait_div: begin
                        if (div_fin) begin
                            res   <= div_q;
                            done  <= 1'b1;
                            state <= idle;
                        end
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

    assign busy = (state != idle);

endmodule

`default_nettype wire

//--- tests/exec_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_assert (
    input wire                 clk,
    input wire                 rst_n,
    input exec_pkg::exec_req_t req,
    input wire                 issue,
    input wire                 flush,
    input wire                 done,
    input wire                 busy
);

    import exec_pkg::*;

    logic seq_op;

    // multiply and the four divide kinds take the long path
    assign seq_op = (req.op == op_mul) || (req.op == op_div) || (req.op == op_divu)
                    || (req.op == op_rem) || (req.op == op_remu);

    // done comes with the return to idle
    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
        else $error("done and busy high together");

    flush_clears_busy: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !busy)
        else $error("busy still high the cycle after flush");

    seq_issue_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (issue && !busy && !flush && seq_op) |=> busy)
        else $error("sequential issue from idle did not raise busy");

    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (!busy && !done))
        else $error("busy or done high coming out of reset");

endmodule

bind exec_unit exec_unit_assert u_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .issue (issue),
    .flush (flush),
    .done  (done),
    .busy  (busy)
);

`default_nettype wire

//--- tests/tb_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;

    import exec_pkg::*;

    localparam int clk_period  = 8;
    localparam int seq_timeout = cycles_per_bit_iter + 8;
    // about 300 operations at 70 cycles each
    localparam int watchdog_ns = 300 * (cycles_per_bit_iter + 6) * clk_period;
    localparam xlen_t min_val  = {1'b1, {(xlen-1){1'b0}}};

    logic      clk;
    logic      rst_n;
    exec_req_t req;
    logic      issue;
    logic      flush;
    xlen_t     res;
    logic      done;
    logic      busy;

    int        mismatches;
    int        failures;
    xlen_t     lcg_state;
    xlen_t     corners [8];

    exec_unit uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .issue (issue),
        .flush (flush),
        .res   (res),
        .done  (done),
        .busy  (busy)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // 64-bit LCG with the high half folded into the low bits
    function automatic xlen_t next_rand();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state ^ (lcg_state >> 32);
    endfunction

    function automatic xlen_t pick_a(input exec_req_t r);
        if (r.sel_a == sel_a_rs1) begin
            return r.word ? {32'b0, r.rs1[31:0]} : r.rs1;
        end
        return r.pc;
    endfunction

    function automatic xlen_t pick_b(input exec_req_t r);
        case (r.sel_b)
            sel_b_rs2: return r.rs2;
            sel_b_csr: return r.csr;
            default:   return r.imm;
        endcase
    endfunction

    function automatic logic is_seq(input alu_op_t op);
        return op inside {op_mul, op_div, op_divu, op_rem, op_remu};
    endfunction

    // expected result straight from the RISC-V rules
    function automatic xlen_t expected_res(input exec_req_t r);
        xlen_t              a;
        xlen_t              b;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic signed [31:0] lo;
        logic [31:0]        lo_sh;
        logic               ovf;
        a   = pick_a(r);
        b   = pick_b(r);
        sa  = a;
        sb  = b;
        lo  = a[31:0];
        ovf = (a == min_val) && (b == '1);
        case (r.op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_pass_a: return a;
            op_pass_b: return b;
            op_xor:    return a ^ b;
            op_or:     return a | b;
            op_and:    return a & b;
            op_sll:    return a << b[5:0];
            op_srl:    return a >> b[5:0];
            op_sra: begin
                if (r.word) begin
                    lo_sh = lo >>> b[5:0];
                    return {32'b0, lo_sh};
                end
                return sa >>> b[5:0];
            end
            op_slt:    return {63'b0, sa < sb};
            op_sltu:   return {63'b0, a < b};
            op_eq:     return {63'b0, a == b};
            op_ge:     return {63'b0, sa >= sb};
            op_geu:    return {63'b0, a >= b};
            op_mul:    return a * b;
            op_div: begin
                if (b == '0) begin
                    return '1;
                end
                if (ovf) begin
                    return min_val;
                end
                sq = sa / sb;
                return sq;
            end
            op_divu:   return (b == '0) ? '1 : a / b;
            op_rem: begin
                if (b == '0) begin
                    return a;
                end
                if (ovf) begin
                    return '0;
                end
                sr = sa % sb;
                return sr;
            end
            op_remu:   return (b == '0) ? a : a % b;
            default:   return '0;
        endcase
    endfunction

    // fills every source with noise and places a and b where the selectors look
    function automatic exec_req_t build_req(input alu_op_t op, input sel_a_t sa,
                                            input sel_b_t sb, input logic word,
                                            input xlen_t a, input xlen_t b);
        exec_req_t r;
        r.op    = op;
        r.sel_a = sa;
        r.sel_b = sb;
        r.word  = word;
        r.pc    = next_rand();
        r.rs1   = next_rand();
        r.rs2   = next_rand();
        r.csr   = next_rand();
        r.imm   = next_rand();
        if (sa == sel_a_rs1) begin
            r.rs1 = a;
        end else begin
            r.pc = a;
        end
        case (sb)
            sel_b_rs2: r.rs2 = b;
            sel_b_csr: r.csr = b;
            default:   r.imm = b;
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp,
                                   input alu_op_t op);
        mismatches++;
        $display("MISMATCH t=%0t %s: got %h, expected %h (op %0d)", $time, name, got, exp, op);
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // issue one operation, wait for done and compare res
    task automatic run_check(input exec_req_t r);
        xlen_t exp;
        logic  seq;
        int    n;
        exp = expected_res(r);
        seq = is_seq(r.op);
        @(posedge clk);
        req   <= r;
        issue <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        n = 1;
        if (!seq) begin
            if (!done) begin
                report_failure($sformatf("no done one cycle after issue of op %0d", r.op));
            end
            if (busy) begin
                report_failure($sformatf("busy raised by single-cycle op %0d", r.op));
            end
        end else begin
            while (!done && n < seq_timeout) begin
                if (!busy) begin
                    report_failure($sformatf("busy low while op %0d is running", r.op));
                end
                @(negedge clk);
                n++;
            end
            if (!done) begin
                report_failure($sformatf("timed out waiting for done of op %0d", r.op));
            end
        end
        if (done && res !== exp) begin
            report_mismatch("res", res, exp, r.op);
        end
    endtask

    task automatic single_cycle_sweep();
        int      i;
        int      j;
        int      k;
        alu_op_t op;
        xlen_t   a;
        xlen_t   b;
        xlen_t   sel;
        // corner pairs, selectors and word mode rotate with the indices
        for (i = 0; i < 8; i++) begin
            for (j = 0; j < 8; j++) begin
                for (k = 0; k < 16; k++) begin
                    op = (k < 15) ? alu_op_t'(k) : 5'd25;
                    run_check(build_req(op, sel_a_t'(i % 4), sel_b_t'(j % 4),
                                        ((i + j + k) % 2) == 1, corners[i], corners[j]));
                end
            end
        end
        for (i = 0; i < 40; i++) begin
            a = next_rand();
            b = next_rand();
            for (k = 0; k < 16; k++) begin
                op  = (k < 15) ? alu_op_t'(k) : 5'd25;
                sel = next_rand();
                run_check(build_req(op, sel[1:0], sel[3:2], sel[4], a, b));
            end
        end
    endtask

    // one issue per cycle with each result one cycle later
    task automatic back_to_back(input int count);
        exec_req_t rs [16];
        xlen_t     sel;
        int        i;
        for (i = 0; i < count; i++) begin
            sel   = next_rand();
            rs[i] = build_req(alu_op_t'(i % 15), sel[1:0], sel[3:2], sel[4],
                              next_rand(), next_rand());
        end
        @(posedge clk);
        req   <= rs[0];
        issue <= 1'b1;
        for (i = 1; i <= count; i++) begin
            @(posedge clk);
            if (i < count) begin
                req <= rs[i];
            end else begin
                issue <= 1'b0;
            end
            @(negedge clk);
            if (!done) begin
                report_failure($sformatf("no done for back-to-back issue %0d", i - 1));
            end
            if (res !== expected_res(rs[i-1])) begin
                report_mismatch("res", res, expected_res(rs[i-1]), rs[i-1].op);
            end
        end
    endtask

    task automatic mul_tests();
        int    i;
        int    j;
        xlen_t sel;
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 4; j++) begin
                run_check(build_req(op_mul, sel_a_rs1, sel_b_rs2, 1'b0, corners[i], corners[j]));
            end
        end
        for (i = 0; i < 20; i++) begin
            sel = next_rand();
            run_check(build_req(op_mul, sel[1:0], sel[3:2], sel[4], next_rand(), next_rand()));
        end
    endtask

    task automatic div_tests();
        alu_op_t ops [4];
        int      i;
        int      j;
        int      k;
        xlen_t   b;
        xlen_t   sel;
        ops[0] = op_div;
        ops[1] = op_divu;
        ops[2] = op_rem;
        ops[3] = op_remu;
        for (k = 0; k < 4; k++) begin
            // divisors zero, one and minus one against every corner dividend
            for (i = 0; i < 8; i++) begin
                for (j = 0; j < 3; j++) begin
                    run_check(build_req(ops[k], sel_a_rs1, sel_b_rs2, 1'b0,
                                        corners[i], corners[j]));
                end
            end
            for (i = 0; i < 12; i++) begin
                sel = next_rand();
                b   = next_rand() >> sel[5:0];
                if (sel[6]) begin
                    b = -b;
                end
                run_check(build_req(ops[k], sel_a_rs1, sel[9:8], 1'b0, next_rand(), b));
            end
        end
    endtask

    task automatic flush_midway(input alu_op_t op);
        int i;
        @(posedge clk);
        req   <= build_req(op, sel_a_rs1, sel_b_rs2, 1'b0, next_rand(), next_rand());
        issue <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        repeat (20) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (i = 0; i < seq_timeout; i++) begin
            @(negedge clk);
            if (busy || done) begin
                report_failure($sformatf("op %0d still active after flush", op));
            end
        end
        run_check(build_req(op, sel_a_rs1, sel_b_rs2, 1'b0, next_rand(), next_rand()));
    endtask

    task automatic flush_with_issue(input alu_op_t op);
        @(posedge clk);
        req   <= build_req(op, sel_a_rs1, sel_b_rs2, 1'b0, next_rand(), next_rand());
        issue <= 1'b1;
        flush <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        flush <= 1'b0;
        @(negedge clk);
        if (busy || done) begin
            report_failure($sformatf("op %0d taken despite flush in the same cycle", op));
        end
    endtask

    // a second issue pulse with req held must not start anything
    task automatic issue_while_busy(input alu_op_t op);
        exec_req_t r;
        xlen_t     exp;
        int        pulses;
        int        i;
        r      = build_req(op, sel_a_rs1, sel_b_rs2, 1'b0, next_rand(), next_rand());
        exp    = expected_res(r);
        pulses = 0;
        @(posedge clk);
        req   <= r;
        issue <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        repeat (10) @(posedge clk);
        issue <= 1'b1;
        @(posedge clk);
        issue <= 1'b0;
        for (i = 0; i < 2 * seq_timeout; i++) begin
            @(negedge clk);
            if (done) begin
                pulses++;
                if (res !== exp) begin
                    report_mismatch("res", res, exp, op);
                end
            end
        end
        if (pulses != 1) begin
            report_failure($sformatf("%0d done pulses for op %0d, one expected", pulses, op));
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns", watchdog_ns);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        issue      = 1'b0;
        flush      = 1'b0;
        req        = '0;
        mismatches = 0;
        failures   = 0;
        lcg_state  = 64'd88;
        corners[0] = '0;
        corners[1] = 64'd1;
        corners[2] = '1;
        corners[3] = min_val;
        corners[4] = ~min_val;
        corners[5] = 64'h0000_0000_8000_0000;
        corners[6] = 64'h0000_0000_ffff_ffff;
        corners[7] = 64'd33;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy || done || res !== '0) begin
            report_failure("outputs not cleared by reset");
        end
        single_cycle_sweep();
        back_to_back(16);
        mul_tests();
        div_tests();
        flush_midway(op_mul);
        flush_midway(op_div);
        flush_midway(op_remu);
        flush_with_issue(op_add);
        flush_with_issue(op_mul);
        issue_while_busy(op_mul);
        issue_while_busy(op_rem);
        repeat (2) @(posedge clk);
        $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/exec_pkg.sv
verilog/int_alu.sv
verilog/seq_multiplier.sv
verilog/seq_divider.sv
verilog/exec_unit.sv
tests/exec_unit_assert.sv
tests/tb_exec_unit.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_exec_unit
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := No errors

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
